// File: Bender.yml
package:
  name: present80

# RTL in compile order, the package first
sources:
  - files:
      - rtl/present_pkg.sv
      - rtl/present_round_if.sv
      - rtl/present_key_schedule.sv
      - rtl/present_round_unit.sv
      - rtl/present_ctrl.sv
      - rtl/present_top.sv

  # Testbench, top module present_tb
  - target: test
    files:
      - verification/present_tb.sv

// File: list.f
rtl/present_pkg.sv
rtl/present_round_if.sv
rtl/present_key_schedule.sv
rtl/present_round_unit.sv
rtl/present_ctrl.sv
rtl/present_top.sv
verification/present_tb.sv

// File: rtl/present_ctrl.sv
// PRESENT operation FSM and round counter with busy and done signalling
module present_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           enc_dec,
    output logic           busy,
    output logic           done,
    present_round_if.ctrl  rif
);
    import present_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    round_ctr_t  ctr_q;
    round_ctr_t  ctr_d;
    logic        dec_q;
    logic        done_q;

    // Level controls decoded from state
    assign rif.load      = (state_q == IDLE) && start;
    assign rif.key_step  = (state_q == KEY_FWD) || (state_q == ROUND);
    assign rif.data_step = (state_q == ROUND);
    assign rif.inverse   = dec_q && (state_q == ROUND);
    assign rif.finish    = (state_q == FINISH);
    assign rif.round_ctr = ctr_q;

    assign busy = (state_q != IDLE);
    assign done = done_q;

    always_comb begin
        state_d = state_q;
        ctr_d   = ctr_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    ctr_d   = round_ctr_t'(1);
                    state_d = enc_dec ? KEY_FWD : ROUND;
                end
            end
            // Decrypt only: walk the key to its last round value
            KEY_FWD: begin
                if (ctr_q == round_ctr_t'(NUM_ROUNDS)) begin
                    state_d = ROUND;
                end else begin
                    ctr_d = ctr_q + round_ctr_t'(1);
                end
            end
            ROUND: begin
                if (dec_q) begin
                    // Counter already sits at 31 here
                    if (ctr_q == round_ctr_t'(1)) begin
                        state_d = FINISH;
                    end else begin
                        ctr_d = ctr_q - round_ctr_t'(1);
                    end
                end else if (ctr_q == round_ctr_t'(NUM_ROUNDS)) begin
                    state_d = FINISH;
                end else begin
                    ctr_d = ctr_q + round_ctr_t'(1);
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            ctr_q   <= '0;
            dec_q   <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            ctr_q   <= ctr_d;
            done_q  <= rif.finish;
            // Direction frozen for the whole operation
            if (rif.load) begin
                dec_q <= enc_dec;
            end
        end
    end

    a_ctrl_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({rif.load, rif.key_step && !rif.data_step, rif.finish})
    );

endmodule

// File: rtl/present_key_schedule.sv
// PRESENT-80 key register with forward and inverse key update
module present_key_schedule (
    input  logic              clk,
    input  logic              rst,
    input  present_pkg::key_t key,
    present_round_if.keys     rif
);
    import present_pkg::*;

    key_t key_q;

    // Forward update path
    key_t key_rot;
    key_t key_fwd;

    // Inverse update path
    key_t key_unmix;
    key_t key_inv;

    // Rotate left by 61, substitute top nibble, mix in round counter
    always_comb begin
        key_rot = {key_q[18:0], key_q[79:19]};
        key_fwd = key_rot;
        key_fwd[79:76] = sbox(key_rot[79:76]);
        key_fwd[19:15] = key_rot[19:15] ^ rif.round_ctr;
    end

    // Same steps undone in reverse order
    always_comb begin
        key_unmix = key_q;
        key_unmix[19:15] = key_q[19:15] ^ rif.round_ctr;
        key_unmix[79:76] = sbox_inv(key_q[79:76]);
        // Rotate right by 61
        key_inv = {key_unmix[60:0], key_unmix[79:61]};
    end

    // Key register, loaded at start and stepped once per round
    always_ff @(posedge clk) begin
        if (rif.load) begin
            key_q <= key;
        end else if (rif.key_step) begin
            key_q <= rif.inverse ? key_inv : key_fwd;
        end
    end

    assign rif.round_key = key_q[79:16];

    // Counter value zero would leave the key unmixed and break the inverse walk
    a_step_ctr_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        rif.key_step |-> (rif.round_ctr != '0)
    );

endmodule

// File: rtl/present_pkg.sv
// PRESENT-80 shared types, round count, controller states and S-box functions
package present_pkg;

    // Datapath widths
    typedef logic [63:0] block_t;
    typedef logic [79:0] key_t;
    typedef logic [63:0] round_key_t;
    typedef logic [4:0]  round_ctr_t;

    // Round-function rounds before the final key whitening
    localparam int NUM_ROUNDS = 31;

    // Operation sequencing
    typedef enum logic [1:0] {
        IDLE,
        KEY_FWD,
        ROUND,
        FINISH
    } ctrl_state_e;

    // Forward 4-bit substitution
    function automatic logic [3:0] sbox(input logic [3:0] x);
        logic [3:0] y;
        case (x)
            4'h0: y = 4'hC;
            4'h1: y = 4'h5;
            4'h2: y = 4'h6;
            4'h3: y = 4'hB;
            4'h4: y = 4'h9;
            4'h5: y = 4'h0;
            4'h6: y = 4'hA;
            4'h7: y = 4'hD;
            4'h8: y = 4'h3;
            4'h9: y = 4'hE;
            4'hA: y = 4'hF;
            4'hB: y = 4'h8;
            4'hC: y = 4'h4;
            4'hD: y = 4'h7;
            4'hE: y = 4'h1;
            default: y = 4'h2;
        endcase
        return y;
    endfunction

    // Inverse substitution, sbox_inv(sbox(x)) == x
    function automatic logic [3:0] sbox_inv(input logic [3:0] x);
        logic [3:0] y;
        case (x)
            4'h0: y = 4'h5;
            4'h1: y = 4'hE;
            4'h2: y = 4'hF;
            4'h3: y = 4'h8;
            4'h4: y = 4'hC;
            4'h5: y = 4'h1;
            4'h6: y = 4'h2;
            4'h7: y = 4'hD;
            4'h8: y = 4'hB;
            4'h9: y = 4'h4;
            4'hA: y = 4'h6;
            4'hB: y = 4'h3;
            4'hC: y = 4'h0;
            4'hD: y = 4'h7;
            4'hE: y = 4'h9;
            default: y = 4'hA;
        endcase
        return y;
    endfunction

endpackage

// File: rtl/present_round_if.sv
// Round control and round key bundle between controller, key schedule and round unit
interface present_round_if;
    import present_pkg::*;

    logic       load;
    logic       key_step;
    logic       data_step;
    logic       inverse;
    logic       finish;
    round_ctr_t round_ctr;
    round_key_t round_key;

    modport ctrl (
        output load, key_step, data_step, inverse, finish, round_ctr
    );

    // Key schedule returns the round key
    modport keys (
        input  load, key_step, data_step, inverse, finish, round_ctr,
        output round_key
    );

    modport data (
        input load, key_step, data_step, inverse, finish, round_ctr, round_key
    );

endinterface

// File: rtl/present_round_unit.sv
// PRESENT round datapath with forward and inverse layers, whitening and output register
module present_round_unit (
    input  logic                clk,
    input  logic                rst,
    input  present_pkg::block_t data_in,
    output present_pkg::block_t data_out,
    present_round_if.data       rif
);
    import present_pkg::*;

    block_t state_q;
    block_t state_mix;
    block_t state_fwd;
    block_t state_inv;

    // S-box applied to all sixteen nibbles
    function automatic block_t s_layer(input block_t x);
        block_t y;
        for (int n = 0; n < 16; n++) begin
            y[4*n +: 4] = sbox(x[4*n +: 4]);
        end
        return y;
    endfunction

    function automatic block_t s_layer_inv(input block_t x);
        block_t y;
        for (int n = 0; n < 16; n++) begin
            y[4*n +: 4] = sbox_inv(x[4*n +: 4]);
        end
        return y;
    endfunction

    // Bit i moves to 16*i mod 63, bit 63 stays put
    function automatic block_t p_layer(input block_t x);
        block_t y;
        y[63] = x[63];
        for (int i = 0; i < 63; i++) begin
            y[(i * 16) % 63] = x[i];
        end
        return y;
    endfunction

    function automatic block_t p_layer_inv(input block_t x);
        block_t y;
        y[63] = x[63];
        for (int i = 0; i < 63; i++) begin
            y[i] = x[(i * 16) % 63];
        end
        return y;
    endfunction

    // Add round key, then either direction of the round
    always_comb begin
        state_mix = state_q ^ rif.round_key;
        state_fwd = p_layer(s_layer(state_mix));
        state_inv = s_layer_inv(p_layer_inv(state_mix));
    end

    always_ff @(posedge clk) begin
        if (rif.load) begin
            state_q <= data_in;
        end else if (rif.data_step) begin
            state_q <= rif.inverse ? state_inv : state_fwd;
        end
    end

    // Final whitening, held until the next finish
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out <= '0;
        end else if (rif.finish) begin
            data_out <= state_mix;
        end
    end

    // Whitening must see the state after the last round, not during it
    a_step_finish_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(rif.data_step && rif.finish)
    );

endmodule

// File: rtl/present_top.sv
// PRESENT-80 iterative cipher core top level
module present_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                enc_dec,
    input  present_pkg::key_t   key,
    input  present_pkg::block_t data_in,
    output present_pkg::block_t data_out,
    output logic                busy,
    output logic                done
);

    present_round_if rif ();

    // Sequencing
    present_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .enc_dec (enc_dec),
        .busy    (busy),
        .done    (done),
        .rif     (rif.ctrl)
    );

    present_key_schedule u_key_schedule (
        .clk (clk),
        .rst (rst),
        .key (key),
        .rif (rif.keys)
    );

    // Block state and result register
    present_round_unit u_round_unit (
        .clk      (clk),
        .rst      (rst),
        .data_in  (data_in),
        .data_out (data_out),
        .rif      (rif.data)
    );

endmodule

// File: verification/present_tb.sv
// PRESENT-80 core testbench with reference model, known vectors, random vectors and watchdog
module present_tb;
    import present_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_BUSY = 4;
    localparam int NUM_OPS = 4 + NUM_RANDOM + 2 * NUM_RANDOM + NUM_BUSY;
    localparam int OP_LIMIT = 70;

    logic   clk;
    logic   rst;
    logic   start;
    logic   enc_dec;
    key_t   key;
    block_t data_in;
    block_t data_out;
    logic   busy;
    logic   done;

    int     checks;
    int     errors;
    int     mark_checks;
    int     mark_errors;
    block_t last_out;

    // Stored random encryptions, decrypted again in the round-trip test
    key_t   rnd_key [NUM_RANDOM];
    block_t rnd_pt [NUM_RANDOM];
    block_t rnd_ct [NUM_RANDOM];

    key_t   k;
    block_t p;
    block_t c;
    block_t res;
    int     lat;

    present_top DUT (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .enc_dec  (enc_dec),
        .key      (key),
        .data_in  (data_in),
        .data_out (data_out),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Bit i of the state goes to 16*(i mod 4) + i/4
    function automatic int bit_dest(input int i);
        return 16 * (i % 4) + i / 4;
    endfunction

    function automatic block_t sub_cells(input block_t x, input bit inv);
        block_t y;
        for (int n = 0; n < 16; n++) begin
            y[4*n +: 4] = inv ? sbox_inv(x[4*n +: 4]) : sbox(x[4*n +: 4]);
        end
        return y;
    endfunction

    function automatic block_t permute(input block_t x, input bit inv);
        block_t y;
        for (int i = 0; i < 64; i++) begin
            if (inv) begin
                y[i] = x[bit_dest(i)];
            end else begin
                y[bit_dest(i)] = x[i];
            end
        end
        return y;
    endfunction

    // Key register update for round counter rc
    function automatic key_t next_key(input key_t kr, input int rc);
        key_t r;
        r = (kr << 61) | (kr >> 19);
        r[79:76] = sbox(r[79:76]);
        r[19:15] = r[19:15] ^ rc[4:0];
        return r;
    endfunction

    function automatic block_t model_encrypt(input key_t kin, input block_t pt);
        key_t   kr;
        block_t st;
        kr = kin;
        st = pt;
        for (int r = 1; r <= NUM_ROUNDS; r++) begin
            st = permute(sub_cells(st ^ kr[79:16], 1'b0), 1'b0);
            kr = next_key(kr, r);
        end
        return st ^ kr[79:16];
    endfunction

    function automatic block_t model_decrypt(input key_t kin, input block_t ct);
        round_key_t rk [1:32];
        key_t       kr;
        block_t     st;
        kr = kin;
        for (int r = 1; r <= 32; r++) begin
            rk[r] = kr[79:16];
            kr = next_key(kr, r);
        end
        st = ct ^ rk[32];
        for (int r = NUM_ROUNDS; r >= 1; r--) begin
            st = sub_cells(permute(st, 1'b1), 1'b1) ^ rk[r];
        end
        return st;
    endfunction

    function automatic key_t rand_key();
        logic [95:0] r;
        r[31:0]  = $urandom();
        r[63:32] = $urandom();
        r[95:64] = $urandom();
        return r[79:0];
    endfunction

    function automatic block_t rand_block();
        block_t r;
        r[31:0]  = $urandom();
        r[63:32] = $urandom();
        return r;
    endfunction

    task automatic check(input string what, input logic [79:0] got, input logic [79:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("[TEST] %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // One operation; disturb pulses start and changes inputs mid-operation
    task automatic run_op(input logic dec, input key_t kin, input block_t din,
                          input bit disturb, output block_t dout, output int edges);
        bit seen;
        @(posedge clk);
        start   <= 1'b1;
        enc_dec <= dec;
        key     <= kin;
        data_in <= din;
        @(posedge clk);
        start <= 1'b0;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < OP_LIMIT) begin
            @(posedge clk);
            edges++;
            if (disturb && edges == 5) begin
                start   <= 1'b1;
                enc_dec <= ~dec;
                key     <= rand_key();
                data_in <= rand_block();
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end else begin
                check("busy during operation", busy, 1'b1);
                check("data_out held between done pulses", data_out, last_out);
            end
        end
        if (!seen) begin
            errors++;
            $display("No done pulse within %0d clock cycles of start, at time %0t",
                     OP_LIMIT, $time);
        end
        check("busy with done", busy, 1'b0);
        dout = data_out;
        last_out = data_out;
        @(negedge clk);
        check("done pulse width", done, 1'b0);
    endtask

    task automatic known_vector(input key_t kin, input block_t pt, input block_t ct);
        block_t got;
        int     edges;
        check("model against published vector", model_encrypt(kin, pt), ct);
        run_op(1'b0, kin, pt, 1'b0, got, edges);
        check("known vector ciphertext", got, ct);
        check("encrypt latency", edges, 32);
    endtask

    initial begin
        void'($urandom(32'h12b6));
        checks = 0;
        errors = 0;
        mark_checks = 0;
        mark_errors = 0;
        last_out = '0;
        rst     <= 1'b1;
        start   <= 1'b0;
        enc_dec <= 1'b0;
        key     <= '0;
        data_in <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        check("busy after reset", busy, 1'b0);
        check("done after reset", done, 1'b0);
        check("data_out after reset", data_out, 64'h0);
        report_test("reset");

        known_vector(80'h0, 64'h0, 64'h5579c1387b228445);
        known_vector(80'h0, 64'hffffffffffffffff, 64'ha112ffc72f68417b);
        known_vector({80{1'b1}}, 64'h0, 64'he72c46c0f5945049);
        known_vector({80{1'b1}}, 64'hffffffffffffffff, 64'h3333dcd3213210d2);
        report_test("known vectors");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_key[i] = rand_key();
            rnd_pt[i]  = rand_block();
            run_op(1'b0, rnd_key[i], rnd_pt[i], 1'b0, rnd_ct[i], lat);
            check("random encryption", rnd_ct[i], model_encrypt(rnd_key[i], rnd_pt[i]));
            check("encrypt latency", lat, 32);
        end
        report_test("random encryption");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            k = rand_key();
            c = rand_block();
            run_op(1'b1, k, c, 1'b0, res, lat);
            check("random decryption", res, model_decrypt(k, c));
            check("decrypt latency", lat, 63);
            // Round trip on the core's own ciphertext
            run_op(1'b1, rnd_key[i], rnd_ct[i], 1'b0, res, lat);
            check("round trip plaintext", res, rnd_pt[i]);
            check("decrypt latency", lat, 63);
        end
        report_test("random decryption");

        for (int i = 0; i < NUM_BUSY; i++) begin
            k = rand_key();
            p = rand_block();
            run_op(i[0], k, p, 1'b1, res, lat);
            check("result with start while busy", res,
                  i[0] ? model_decrypt(k, p) : model_encrypt(k, p));
            check("latency with start while busy", lat, i[0] ? 63 : 32);
        end
        report_test("busy behavior");

        $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Bound on the whole run from the operation count
    initial begin
        #((NUM_OPS * 70 + 100) * CLK_PERIOD);
        $display("Watchdog timed out after %0d clock periods, the run did not complete",
                 NUM_OPS * 70 + 100);
        $display("Result: FAILED");
        $finish;
    end

endmodule
